//--- verilog/sysctl_pkg.sv
// bus widths, request opcodes and reset-control constants, imported by every system-control block
`default_nettype none

package sysctl_pkg;

	// peripheral interconnect word size
	localparam int DATA_W = 32;

	// word address, the byte lane bits are not carried
	localparam int ADDR_W = 30;

	// request kind carried next to the strobe
	typedef enum logic [0:0] {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} req_op_e;

	// width of the external reset countdown
	localparam int RST_CNTR_W = 6;

	// bit1 and bit1+bit0 of the control word pick the reset action
	// 11 cold reset, 10 warm reset, 01 power-off, 00 no action
	localparam int RSTCTL_BIT0 = 0;
	localparam int RSTCTL_BIT1 = 1;

endpackage

`default_nettype wire

//--- verilog/soc_map_pkg.sv
// slave address map and device table contents, imported by the decoder, lookup and responder
`default_nettype none

package soc_map_pkg;

	// slave index order on the interconnect, the last entry catches stray addresses
	typedef enum logic [3:0] {
		SLV_SDCARD,
		SLV_DEVTBL,
		SLV_GPIO,
		SLV_DMA,
		SLV_INTCTRL,
		SLV_UART,
		SLV_RAM,
		SLV_RAMCTRL,
		SLV_BOOTLDR,
		SLV_INVALID
	} slave_e;

	localparam int SLAVE_COUNT = 10;

	typedef logic [sysctl_pkg::ADDR_W-1:0] map_word_t;

	// map sizes in words
	localparam map_word_t MAPSZ [SLAVE_COUNT] = '{
		30'd64,
		30'd64,
		30'd16,
		30'd16,
		30'd16,
		30'd16,
		30'h8000000,
		30'h1000,
		30'h400,
		30'h400
	};

	// slaves sit back to back starting at address 0
	function automatic map_word_t map_base(input int idx);
		map_word_t sum;
		sum = '0;
		for (int i = 0; i < idx; i++) begin
			sum = sum + MAPSZ[i];
		end
		return sum;
	endfunction

	localparam map_word_t BASE [SLAVE_COUNT] = '{
		map_base(0), map_base(1), map_base(2), map_base(3), map_base(4),
		map_base(5), map_base(6), map_base(7), map_base(8), map_base(9)
	};

	localparam logic [sysctl_pkg::DATA_W-1:0] DEV_ID [SLAVE_COUNT] = '{
		32'd4, 32'd7, 32'd6, 32'd2, 32'd3, 32'd5, 32'd1, 32'd0, 32'd0, 32'd0
	};

	// set for slaves wired to the interrupt controller
	localparam logic USEINTR [SLAVE_COUNT] = '{
		1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0
	};

	// control word, then an id and a map size word per slave
	localparam int DEVTBL_WORDS = 1 + 2 * SLAVE_COUNT;

endpackage

`default_nettype wire

//--- verilog/addr_decoder.sv
// first pipeline stage, finds the addressed slave and the word offset within it for each request
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
	input  wire                             clk100mhz_i,
	input  wire                             rst_p,
	input  wire                             req_stb_i,
	input  wire sysctl_pkg::req_op_e        req_op_i,
	input  wire [sysctl_pkg::ADDR_W-1:0]    req_addr_i,
	input  wire [sysctl_pkg::DATA_W-1:0]    req_data_i,
	output logic                            dec_stb_o,
	output sysctl_pkg::req_op_e             dec_op_o,
	output soc_map_pkg::slave_e             dec_slave_o,
	output logic [sysctl_pkg::ADDR_W-1:0]   dec_offset_o,
	output logic [sysctl_pkg::DATA_W-1:0]   dec_data_o
);
	import sysctl_pkg::*;
	import soc_map_pkg::*;

	logic [SLAVE_COUNT-2:0] hit;
	slave_e                 slave_sel;

	// one base and limit check per real slave, all in parallel
	always_comb begin
		for (int i = 0; i < SLAVE_COUNT - 1; i++) begin
			hit[i] = (req_addr_i >= BASE[i]) && (req_addr_i < BASE[i] + MAPSZ[i]);
		end
	end

	// ranges never overlap so at most one hit is set
	always_comb begin
		slave_sel = SLV_INVALID;
		for (int i = 0; i < SLAVE_COUNT - 1; i++) begin
			if (hit[i]) begin
				slave_sel = slave_e'(i);
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			dec_stb_o <= 1'b0;
		end else begin
			dec_stb_o <= req_stb_i;
		end
	end

	// beyond the map the offset is taken from the invalid device base
	always_ff @(posedge clk100mhz_i) begin
		dec_op_o     <= req_op_i;
		dec_slave_o  <= slave_sel;
		dec_offset_o <= req_addr_i - BASE[slave_sel];
		dec_data_o   <= req_data_i;
	end

endmodule

`default_nettype wire

//--- verilog/devtbl_lookup.sv
// device table read port, registers the table word picked by the low request address bits
`timescale 1ns/1ps
`default_nettype none

module devtbl_lookup (
	input  wire                           clk100mhz_i,
	input  wire [sysctl_pkg::ADDR_W-1:0]  req_addr_i,
	input  wire                           pwroff_i,
	output logic [sysctl_pkg::DATA_W-1:0] tbl_word_o
);
	import sysctl_pkg::*;
	import soc_map_pkg::*;

	logic [4:0]        tbl_idx;
	logic [4:0]        entry_off;
	logic [3:0]        slv_idx;
	logic [DATA_W-1:0] tbl_word;

	// devtbl base is 64 aligned so the low address bits are the table offset
	assign tbl_idx = req_addr_i[4:0];

	// past the control word, entries come in pairs of id then map size
	assign entry_off = tbl_idx - 5'd1;
	assign slv_idx   = entry_off[4:1];

	always_comb begin
		tbl_word = '0;
		if (tbl_idx == 5'd0) begin
			tbl_word[RSTCTL_BIT0] = pwroff_i;
		end else if (tbl_idx < 5'(DEVTBL_WORDS)) begin
			if (!entry_off[0]) begin
				tbl_word = DEV_ID[slv_idx];
			end else begin
				// interrupt flag on top, bit 30 stays clear
				tbl_word = {USEINTR[slv_idx], 1'b0, MAPSZ[slv_idx]};
			end
		end
	end

	// no strobe needed, the responder only looks here on a devtbl hit
	always_ff @(posedge clk100mhz_i) begin
		tbl_word_o <= tbl_word;
	end

endmodule

`default_nettype wire

//--- verilog/sysctl_responder.sv
// second pipeline stage, builds the response and runs the reset countdown and power-off control
`timescale 1ns/1ps
`default_nettype none

module sysctl_responder (
	input  wire                           clk100mhz_i,
	input  wire                           rst_p,
	input  wire                           dec_stb_i,
	input  wire sysctl_pkg::req_op_e      dec_op_i,
	input  wire soc_map_pkg::slave_e      dec_slave_i,
	input  wire [sysctl_pkg::ADDR_W-1:0]  dec_offset_i,
	input  wire [sysctl_pkg::DATA_W-1:0]  dec_data_i,
	input  wire [sysctl_pkg::DATA_W-1:0]  tbl_word_i,
	output logic                          resp_stb_o,
	output logic [sysctl_pkg::DATA_W-1:0] resp_data_o,
	output soc_map_pkg::slave_e           resp_slave_o,
	output logic                          resp_err_o,
	output logic                          sys_rst_o,
	output logic                          pwroff_o
);
	import sysctl_pkg::*;
	import soc_map_pkg::*;

	typedef enum logic [1:0] {
		RUN,
		COUNTDOWN,
		OFF
	} rst_state_e;

	rst_state_e            state;
	logic [RST_CNTR_W-1:0] rst_cntr;
	logic                  tbl_hit;
	logic                  ctl_wr;
	logic                  cold_rst;
	logic                  warm_rst;
	logic                  pwr_off;

	// offsets past the table read zero even where the low bits alias
	assign tbl_hit = (dec_slave_i == SLV_DEVTBL) && (dec_offset_i < ADDR_W'(DEVTBL_WORDS));

	// only a write to devtbl offset 0 reaches the reset control
	assign ctl_wr = dec_stb_i && (dec_op_i == OP_WRITE) && (dec_slave_i == SLV_DEVTBL)
		&& (dec_offset_i == '0);
	assign cold_rst = ctl_wr && dec_data_i[RSTCTL_BIT1] && dec_data_i[RSTCTL_BIT0];
	assign warm_rst = ctl_wr && dec_data_i[RSTCTL_BIT1] && !dec_data_i[RSTCTL_BIT0];
	assign pwr_off  = ctl_wr && !dec_data_i[RSTCTL_BIT1] && dec_data_i[RSTCTL_BIT0];

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			resp_stb_o <= 1'b0;
		end else begin
			resp_stb_o <= dec_stb_i;
		end
	end

	// writes and non-table slaves answer with zero
	always_ff @(posedge clk100mhz_i) begin
		resp_slave_o <= dec_slave_i;
		resp_err_o   <= (dec_slave_i == SLV_INVALID);
		if ((dec_op_i == OP_READ) && tbl_hit) begin
			resp_data_o <= tbl_word_i;
		end else begin
			resp_data_o <= '0;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			state    <= COUNTDOWN;
			rst_cntr <= '1;
		end else begin
			if (cold_rst || warm_rst) begin
				rst_cntr <= '1;
			end else if (rst_cntr != '0) begin
				rst_cntr <= rst_cntr - 1'b1;
			end
			case (state)
				RUN: begin
					if (pwr_off) begin
						state <= OFF;
					end else if (cold_rst || warm_rst) begin
						state <= COUNTDOWN;
					end
				end
				COUNTDOWN: begin
					if (pwr_off) begin
						state <= OFF;
					end else if (!cold_rst && !warm_rst && (rst_cntr <= RST_CNTR_W'(1))) begin
						state <= RUN;
					end
				end
				// a warm reset keeps the board off, only a cold one wakes it
				OFF: begin
					if (cold_rst) begin
						state <= COUNTDOWN;
					end
				end
				default: state <= COUNTDOWN;
			endcase
		end
	end

	// RUN is only held with the counter at zero and no power-off
	assign sys_rst_o = (state != RUN);
	assign pwroff_o  = (state == OFF);

endmodule

`default_nettype wire

//--- verilog/sysctl_top.sv
// system-control top level, answers interconnect requests two cycles later and drives system reset
`timescale 1ns/1ps
`default_nettype none

module sysctl_top (
	input  wire                           clk100mhz_i,
	input  wire                           rst_p,
	input  wire                           req_stb_i,
	input  wire sysctl_pkg::req_op_e      req_op_i,
	input  wire [sysctl_pkg::ADDR_W-1:0]  req_addr_i,
	input  wire [sysctl_pkg::DATA_W-1:0]  req_data_i,
	output logic                          resp_stb_o,
	output logic [sysctl_pkg::DATA_W-1:0] resp_data_o,
	output soc_map_pkg::slave_e           resp_slave_o,
	output logic                          resp_err_o,
	output logic                          sys_rst_o,
	output logic                          pwroff_o
);
	import sysctl_pkg::*;
	import soc_map_pkg::*;

	logic              dec_stb;
	req_op_e           dec_op;
	slave_e            dec_slave;
	logic [ADDR_W-1:0] dec_offset;
	logic [DATA_W-1:0] dec_data;
	logic [DATA_W-1:0] tbl_word;

	addr_decoder u_addr_decoder (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.req_stb_i    (req_stb_i),
		.req_op_i     (req_op_i),
		.req_addr_i   (req_addr_i),
		.req_data_i   (req_data_i),
		.dec_stb_o    (dec_stb),
		.dec_op_o     (dec_op),
		.dec_slave_o  (dec_slave),
		.dec_offset_o (dec_offset),
		.dec_data_o   (dec_data)
	);

	// table word lands in the same cycle as the decode result
	devtbl_lookup u_devtbl_lookup (
		.clk100mhz_i (clk100mhz_i),
		.req_addr_i  (req_addr_i),
		.pwroff_i    (pwroff_o),
		.tbl_word_o  (tbl_word)
	);

	sysctl_responder u_sysctl_responder (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.dec_stb_i    (dec_stb),
		.dec_op_i     (dec_op),
		.dec_slave_i  (dec_slave),
		.dec_offset_i (dec_offset),
		.dec_data_i   (dec_data),
		.tbl_word_i   (tbl_word),
		.resp_stb_o   (resp_stb_o),
		.resp_data_o  (resp_data_o),
		.resp_slave_o (resp_slave_o),
		.resp_err_o   (resp_err_o),
		.sys_rst_o    (sys_rst_o),
		.pwroff_o     (pwroff_o)
	);

endmodule

`default_nettype wire

//--- bench/sysctl_checker.sv
// reference model that predicts every system-control response and reset output and compares it with the DUT
`timescale 1ns/1ps
`default_nettype none

module sysctl_checker (
	input  wire                          clk100mhz_i,
	input  wire                          rst_p,
	input  wire                          req_stb_i,
	input  wire sysctl_pkg::req_op_e     req_op_i,
	input  wire [sysctl_pkg::ADDR_W-1:0] req_addr_i,
	input  wire [sysctl_pkg::DATA_W-1:0] req_data_i,
	input  wire                          resp_stb_i,
	input  wire [sysctl_pkg::DATA_W-1:0] resp_data_i,
	input  wire soc_map_pkg::slave_e     resp_slave_i,
	input  wire                          resp_err_i,
	input  wire                          sys_rst_i,
	input  wire                          pwroff_i,
	output int                           value_errs_o,
	output int                           proto_errs_o,
	output int                           pending_o
);
	import sysctl_pkg::*;
	import soc_map_pkg::*;

	typedef struct packed {
		int                cyc;
		slave_e            slave;
		logic [DATA_W-1:0] data;
	} expect_t;

	expect_t               exp_q[$];
	expect_t               head;
	int                    cyc = 0;
	int                    value_errs = 0;
	int                    proto_errs = 0;
	logic                  model_on = 1'b0;
	logic                  m_pwroff;
	logic [1:0]            ctl_pend;
	logic [RST_CNTR_W-1:0] m_cntr;

	// slave windows are packed from address 0 in index order
	function automatic longint window_base(input int idx);
		longint lo;
		lo = 0;
		for (int i = 0; i < idx; i++) begin
			lo = lo + longint'(MAPSZ[i]);
		end
		return lo;
	endfunction

	function automatic slave_e find_slave(input longint addr);
		slave_e s;
		s = SLV_INVALID;
		for (int i = 0; i < SLAVE_COUNT - 1; i++) begin
			if (addr >= window_base(i) && addr < window_base(i + 1)) begin
				s = slave_e'(i);
			end
		end
		return s;
	endfunction

	// the control word comes first and id and size pairs follow up to the last slave
	function automatic logic [DATA_W-1:0] table_word(input longint off, input logic pwr);
		logic [DATA_W-1:0] w;
		int                slv;
		w = '0;
		slv = int'((off - 1) / 2);
		if (off == 0) begin
			w[0] = pwr;
		end else if (off <= 2 * SLAVE_COUNT) begin
			if (off % 2 == 1) begin
				w = DEV_ID[slv];
			end else begin
				w[31] = USEINTR[slv];
				w[29:0] = MAPSZ[slv];
			end
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp);
			value_errs++;
		end
	endtask

	always @(posedge clk100mhz_i) begin
		expect_t e;
		cyc++;
		if (rst_p) begin
			exp_q.delete();
			model_on = 1'b1;
			m_cntr   = '1;
			m_pwroff = 1'b0;
			ctl_pend = 2'b00;
		end else if (model_on) begin
			if (resp_stb_i && exp_q.size() == 0) begin
				$display("%0t: response strobe with no request outstanding", $time);
				proto_errs++;
			end else if (resp_stb_i) begin
				head = exp_q.pop_front();
				if (head.cyc != cyc - 2) begin
					$display("%0t: response came %0d cycles after its request instead of 2",
						$time, cyc - head.cyc);
					proto_errs++;
				end
				check_value("resp_slave_o", DATA_W'(resp_slave_i), DATA_W'(head.slave));
				check_value("resp_err_o", DATA_W'(resp_err_i),
					DATA_W'(head.slave == SLV_INVALID));
				check_value("resp_data_o", resp_data_i, head.data);
			end else if (exp_q.size() != 0 && exp_q[0].cyc <= cyc - 2) begin
				$display("%0t: no response for the request taken in cycle %0d",
					$time, exp_q[0].cyc);
				proto_errs++;
				void'(exp_q.pop_front());
			end
			// sampled outputs hold the state left by the previous edge
			check_value("sys_rst_o", DATA_W'(sys_rst_i), DATA_W'(m_cntr != '0 || m_pwroff));
			check_value("pwroff_o", DATA_W'(pwroff_i), DATA_W'(m_pwroff));
			if (req_stb_i) begin
				e.cyc   = cyc;
				e.slave = find_slave(longint'(req_addr_i));
				e.data  = '0;
				if (req_op_i == OP_READ && e.slave == SLV_DEVTBL) begin
					e.data = table_word(longint'(req_addr_i) - window_base(SLV_DEVTBL), m_pwroff);
				end
				exp_q.push_back(e);
			end
			// a control write taken one edge ago acts on this edge
			if (ctl_pend[1]) begin
				m_cntr = '1;
			end else if (m_cntr != '0) begin
				m_cntr = m_cntr - RST_CNTR_W'(1);
			end
			if (ctl_pend == 2'b11) begin
				m_pwroff = 1'b0;
			end else if (ctl_pend == 2'b01) begin
				m_pwroff = 1'b1;
			end
			ctl_pend = 2'b00;
			if (req_stb_i && req_op_i == OP_WRITE
				&& longint'(req_addr_i) == window_base(SLV_DEVTBL)) begin
				ctl_pend = req_data_i[1:0];
			end
		end
		value_errs_o <= value_errs;
		proto_errs_o <= proto_errs;
		pending_o    <= exp_q.size();
	end

endmodule

`default_nettype wire

//--- bench/tb_sysctl.sv
// testbench top that drives seeded random requests and reset-control writes into the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_sysctl;
	import sysctl_pkg::*;
	import soc_map_pkg::*;

	// cycles allowed for a pipeline drain plus the reset countdown
	localparam int WAIT_LIMIT = 300;

	logic              clk100mhz_i;
	logic              rst_p;
	logic              req_stb_i;
	req_op_e           req_op_i;
	logic [ADDR_W-1:0] req_addr_i;
	logic [DATA_W-1:0] req_data_i;
	logic              resp_stb_o;
	logic [DATA_W-1:0] resp_data_o;
	slave_e            resp_slave_o;
	logic              resp_err_o;
	logic              sys_rst_o;
	logic              pwroff_o;
	int                value_errs;
	int                proto_errs;
	int                pending;
	int                timeouts = 0;

	sysctl_top dut (.*);

	sysctl_checker u_checker (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.req_stb_i    (req_stb_i),
		.req_op_i     (req_op_i),
		.req_addr_i   (req_addr_i),
		.req_data_i   (req_data_i),
		.resp_stb_i   (resp_stb_o),
		.resp_data_i  (resp_data_o),
		.resp_slave_i (resp_slave_o),
		.resp_err_i   (resp_err_o),
		.sys_rst_i    (sys_rst_o),
		.pwroff_i     (pwroff_o),
		.value_errs_o (value_errs),
		.proto_errs_o (proto_errs),
		.pending_o    (pending)
	);

	always #5 clk100mhz_i = ~clk100mhz_i;

	task automatic drive_bus(input logic stb, input req_op_e op, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		@(posedge clk100mhz_i);
		req_stb_i  <= stb;
		req_op_i   <= op;
		req_addr_i <= addr;
		req_data_i <= data;
	endtask

	// idle the bus until all responses are in and, if asked, the system is out of reset
	task automatic idle_while_busy(input logic want_run, input string what);
		int n;
		n = 0;
		repeat (2) drive_bus(1'b0, OP_READ, '0, '0);
		while ((pending != 0 || (want_run && sys_rst_o)) && n < WAIT_LIMIT) begin
			drive_bus(1'b0, OP_READ, '0, '0);
			n++;
		end
		if (pending != 0 || (want_run && sys_rst_o)) begin
			$display("%0t: timed out waiting for %s", $time, what);
			timeouts++;
		end
	endtask

	// mostly near slave edges, inside devtbl and past the end of the map
	function automatic logic [ADDR_W-1:0] pick_addr();
		logic [ADDR_W-1:0] edge_addr;
		edge_addr = BASE[$urandom_range(1, SLAVE_COUNT - 1)];
		case ($urandom_range(0, 3))
			0: return ADDR_W'($urandom);
			1: return edge_addr + ADDR_W'($urandom_range(0, 3)) - ADDR_W'(2);
			2: return BASE[SLV_DEVTBL] + ADDR_W'($urandom_range(0, 63));
			default: return BASE[SLV_INVALID] + MAPSZ[SLV_INVALID] + ADDR_W'($urandom_range(0, 7))
				- ADDR_W'(4);
		endcase
	endfunction

	initial begin
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		clk100mhz_i = 1'b0;
		rst_p       = 1'b1;
		req_stb_i   = 1'b0;
		req_op_i    = OP_READ;
		req_addr_i  = '0;
		req_data_i  = '0;
		void'($urandom(48));
		repeat (2) @(posedge clk100mhz_i);
		rst_p <= 1'b0;
		idle_while_busy(1'b1, "the power-on reset countdown");
		repeat (300) begin
			drive_bus(1'b1, OP_READ, pick_addr(), $urandom);
			if ($urandom_range(0, 2) == 0) begin
				drive_bus(1'b0, OP_READ, '0, '0);
			end
		end
		for (int off = 0; off < 32; off++) begin
			drive_bus(1'b1, OP_READ, BASE[SLV_DEVTBL] + ADDR_W'(off), '0);
		end
		idle_while_busy(1'b0, "the read responses");
		drive_bus(1'b1, OP_WRITE, BASE[SLV_DEVTBL], 32'h2);
		idle_while_busy(1'b1, "the end of the warm reset");
		// back to back traffic where the control word never sees reset bits
		repeat (400) begin
			addr = pick_addr();
			data = $urandom;
			if (addr == BASE[SLV_DEVTBL]) begin
				data[1:0] = 2'b00;
			end
			drive_bus(1'b1, req_op_e'($urandom_range(0, 1)), addr, data);
		end
		idle_while_busy(1'b0, "the mixed traffic responses");
		drive_bus(1'b1, OP_WRITE, BASE[SLV_DEVTBL], 32'h3);
		idle_while_busy(1'b1, "the end of the cold reset");
		drive_bus(1'b1, OP_READ, BASE[SLV_DEVTBL], '0);
		drive_bus(1'b1, OP_WRITE, BASE[SLV_DEVTBL], 32'h1);
		idle_while_busy(1'b0, "the power-off response");
		// stay off well past a full countdown
		repeat (100) drive_bus(1'b0, OP_READ, '0, '0);
		rst_p <= 1'b1;
		repeat (2) @(posedge clk100mhz_i);
		rst_p <= 1'b0;
		idle_while_busy(1'b1, "the countdown after the final reset");
		// one more edge so the checker counts its compare of the outputs seen at the exit
		drive_bus(1'b0, OP_READ, '0, '0);
		$display("errors: %0d value, %0d protocol, %0d timeout", value_errs, proto_errs, timeouts);
		if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/sysctl_pkg.sv
verilog/soc_map_pkg.sv
verilog/addr_decoder.sv
verilog/devtbl_lookup.sv
verilog/sysctl_responder.sv
verilog/sysctl_top.sv
bench/sysctl_checker.sv
bench/tb_sysctl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_sysctl
FILELIST  := list.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJDIR)
